//--- hdl/fft_defines.svh
// ===================================================================
// FFT8 SDF parameters
// Transform size, sample widths and twiddle fixed-point format
// ===================================================================
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// Points per frame
`define FFT_N      8

// Input component width, signed
`define SAMPLE_W   15

// Output component width, one growth bit per stage
`define OUT_W      18

// Twiddle component width and fractional bits (Q1.14)
`define COEF_W     16
`define COEF_FRAC  14

`endif

//--- hdl/fft_pkg.sv
// ===================================================================
// FFT shared types
// Twiddle coefficient type and stage controller phases
// ===================================================================
`include "fft_defines.svh"

package fft_pkg;

    // Signed twiddle component in Q1.14
    typedef logic signed [`COEF_W-1:0] coef_t;

    // Stage controller phase
    // Drain phases may overlap the fill of the next block
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_FILL,
        PH_BFLY,
        PH_DRAIN,
        PH_DRAIN_FILL
    } stage_phase_t;

endpackage

//--- hdl/twiddle_rom.sv
// ===================================================================
// Twiddle table
// W8^k for k = 0..3 in Q1.14, answered combinationally
// ===================================================================
`timescale 1ns/1ps
`include "fft_defines.svh"

module twiddle_rom (
    input  logic [1:0]     tw_index_i,
    output fft_pkg::coef_t tw_re_o,
    output fft_pkg::coef_t tw_im_o
);
    import fft_pkg::*;

    // Unity and cos(pi/4) scaled by 2^14
    localparam coef_t TW_ONE = coef_t'(1 << `COEF_FRAC);
    localparam coef_t TW_C45 = coef_t'(11585);

    always_comb begin
        case (tw_index_i)
            2'd0: begin
                tw_re_o = TW_ONE;
                tw_im_o = '0;
            end
            2'd1: begin
                tw_re_o = TW_C45;
                tw_im_o = -TW_C45;
            end
            2'd2: begin
                tw_re_o = '0;
                tw_im_o = -TW_ONE;
            end
            default: begin
                // k = 3
                tw_re_o = -TW_C45;
                tw_im_o = -TW_C45;
            end
        endcase
    end

endmodule

//--- hdl/twiddle_mul.sv
// ===================================================================
// Twiddle multiplier
// Complex product, arithmetic shift by the fraction, then saturation
// ===================================================================
`timescale 1ns/1ps
`include "fft_defines.svh"

module twiddle_mul #(
    parameter int W = 16
) (
    input  logic signed [W-1:0] a_re_i,
    input  logic signed [W-1:0] a_im_i,
    input  fft_pkg::coef_t      tw_re_i,
    input  fft_pkg::coef_t      tw_im_i,
    output logic signed [W-1:0] p_re_o,
    output logic signed [W-1:0] p_im_o
);
    // Full product width plus one bit for the sum of two products
    localparam int PW = W + `COEF_W + 1;

    localparam logic signed [PW-1:0] SAT_MAX = {{(PW - W + 1){1'b0}}, {(W - 1){1'b1}}};
    localparam logic signed [PW-1:0] SAT_MIN = {{(PW - W + 1){1'b1}}, {(W - 1){1'b0}}};

    logic signed [PW-1:0] re_full, im_full;
    logic signed [PW-1:0] re_sh, im_sh;

    // Clamp to the W-bit signed range
    function automatic logic signed [W-1:0] sat(input logic signed [PW-1:0] v);
        if (v > SAT_MAX) begin
            return SAT_MAX[W-1:0];
        end else if (v < SAT_MIN) begin
            return SAT_MIN[W-1:0];
        end
        return v[W-1:0];
    endfunction

    // (a_re + j a_im)(t_re + j t_im), all operands signed
    assign re_full = a_re_i * tw_re_i - a_im_i * tw_im_i;
    assign im_full = a_re_i * tw_im_i + a_im_i * tw_re_i;

    // Truncates toward minus infinity
    assign re_sh = re_full >>> `COEF_FRAC;
    assign im_sh = im_full >>> `COEF_FRAC;

    assign p_re_o = sat(re_sh);
    assign p_im_o = sat(im_sh);

endmodule

//--- hdl/sdf_stage_ctrl.sv
// ===================================================================
// SDF stage controller
// Sequences fill, butterfly and drain and selects the twiddle factor
// ===================================================================
`timescale 1ns/1ps
`include "fft_defines.svh"

module sdf_stage_ctrl #(
    parameter int DELAY = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_i,
    output fft_pkg::stage_phase_t phase_o,
    output logic [1:0]           tw_index_o,
    output logic                 valid_o
);
    import fft_pkg::*;

    localparam int CNT_W = $clog2(2 * DELAY);
    // Twiddle step per drain position
    localparam int TW_STEP = `FFT_N / (2 * DELAY);
    localparam logic [CNT_W-1:0] LAST_HALF = CNT_W'(DELAY - 1);
    localparam logic [CNT_W-1:0] LAST_BLOCK = CNT_W'(2 * DELAY - 1);
    // A one-deep stage goes straight to the butterfly after one sample
    localparam stage_phase_t START_PH = (DELAY == 1) ? PH_BFLY : PH_FILL;

    stage_phase_t phase_q, phase_nxt;
    // Position of the incoming sample within its block
    logic [CNT_W-1:0] in_cnt_q, in_cnt_nxt;
    // Position within the drain of the previous block
    logic [CNT_W-1:0] dr_cnt_q, dr_cnt_nxt;
    logic draining;

    assign draining = (phase_q == PH_DRAIN) || (phase_q == PH_DRAIN_FILL);

    // ==================================================================
    // Next-state logic
    // ==================================================================
    always_comb begin
        phase_nxt  = phase_q;
        in_cnt_nxt = in_cnt_q;
        dr_cnt_nxt = dr_cnt_q;
        case (phase_q)
            PH_IDLE: begin
                // First strobe of a block
                if (valid_i) begin
                    in_cnt_nxt = CNT_W'(1);
                    phase_nxt  = START_PH;
                end
            end
            PH_FILL: begin
                in_cnt_nxt = in_cnt_q + 1'b1;
                if (in_cnt_q == LAST_HALF) begin
                    phase_nxt = PH_BFLY;
                end
            end
            PH_BFLY: begin
                in_cnt_nxt = in_cnt_q + 1'b1;
                // Last sample of the block, differences now sit in the line
                if (in_cnt_q == LAST_BLOCK) begin
                    in_cnt_nxt = '0;
                    dr_cnt_nxt = '0;
                    phase_nxt  = PH_DRAIN;
                end
            end
            PH_DRAIN: begin
                dr_cnt_nxt = dr_cnt_q + 1'b1;
                if (valid_i) begin
                    in_cnt_nxt = CNT_W'(1);
                end
                if (dr_cnt_q == LAST_HALF) begin
                    dr_cnt_nxt = '0;
                    phase_nxt  = valid_i ? START_PH : PH_IDLE;
                end else if (valid_i) begin
                    // New block arrives while the drain is still running
                    phase_nxt = PH_DRAIN_FILL;
                end
            end
            PH_DRAIN_FILL: begin
                dr_cnt_nxt = dr_cnt_q + 1'b1;
                in_cnt_nxt = in_cnt_q + 1'b1;
                if (dr_cnt_q == LAST_HALF) begin
                    dr_cnt_nxt = '0;
                    // Back-to-back blocks finish fill and drain together
                    phase_nxt  = (in_cnt_q == LAST_HALF) ? PH_BFLY : PH_FILL;
                end
            end
            default: phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q  <= PH_IDLE;
            in_cnt_q <= '0;
            dr_cnt_q <= '0;
            valid_o  <= 1'b0;
        end else begin
            phase_q  <= phase_nxt;
            in_cnt_q <= in_cnt_nxt;
            dr_cnt_q <= dr_cnt_nxt;
            // Aligned with the registered stage output
            valid_o  <= (phase_q == PH_BFLY) || draining;
        end
    end

    assign phase_o    = phase_q;
    assign tw_index_o = 2'(dr_cnt_q * TW_STEP);

endmodule

//--- hdl/sdf_stage.sv
// ===================================================================
// SDF stage
// Delay-feedback radix-2 DIF butterfly with twiddle on the drain path
// ===================================================================
`timescale 1ns/1ps

module sdf_stage #(
    parameter int DELAY = 1,
    parameter int IN_W  = 17
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_i,
    input  logic signed [IN_W-1:0] data_re_i,
    input  logic signed [IN_W-1:0] data_im_i,
    output logic                   valid_o,
    output logic signed [IN_W:0]   data_re_o,
    output logic signed [IN_W:0]   data_im_o
);
    import fft_pkg::*;

    // Stage works one bit wider than its input
    localparam int DW = IN_W + 1;

    stage_phase_t phase;
    logic [1:0]   tw_index;
    coef_t        tw_re, tw_im;
    logic         draining;
    logic         shift_en;

    logic signed [DW-1:0] in_re_x, in_im_x;
    logic signed [DW-1:0] head_re, head_im;
    logic signed [DW-1:0] sum_re, sum_im;
    logic signed [DW-1:0] dif_re, dif_im;
    logic signed [DW-1:0] tail_re, tail_im;
    logic signed [DW-1:0] prod_re, prod_im;

    // Feedback delay line, entry 0 is the oldest
    logic signed [DW-1:0] dl_re [DELAY];
    logic signed [DW-1:0] dl_im [DELAY];

    sdf_stage_ctrl #(
        .DELAY      (DELAY)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .phase_o    (phase),
        .tw_index_o (tw_index),
        .valid_o    (valid_o)
    );

    twiddle_rom u_rom (
        .tw_index_i (tw_index),
        .tw_re_o    (tw_re),
        .tw_im_o    (tw_im)
    );

    twiddle_mul #(
        .W       (DW)
    ) u_mul (
        .a_re_i  (head_re),
        .a_im_i  (head_im),
        .tw_re_i (tw_re),
        .tw_im_i (tw_im),
        .p_re_o  (prod_re),
        .p_im_o  (prod_im)
    );

    // ==================================================================
    // Butterfly
    // ==================================================================
    assign in_re_x = {data_re_i[IN_W-1], data_re_i};
    assign in_im_x = {data_im_i[IN_W-1], data_im_i};
    assign head_re = dl_re[0];
    assign head_im = dl_im[0];

    // x[n] + x[n+D] goes out, x[n] - x[n+D] goes back into the line
    assign sum_re = head_re + in_re_x;
    assign sum_im = head_im + in_im_x;
    assign dif_re = head_re - in_re_x;
    assign dif_im = head_im - in_im_x;

    assign draining = (phase == PH_DRAIN) || (phase == PH_DRAIN_FILL);
    // Line moves on every strobe and on every drain cycle
    assign shift_en = valid_i || draining;
    assign tail_re  = (phase == PH_BFLY) ? dif_re : in_re_x;
    assign tail_im  = (phase == PH_BFLY) ? dif_im : in_im_x;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = 0; i < DELAY - 1; i++) begin
                dl_re[i] <= dl_re[i+1];
                dl_im[i] <= dl_im[i+1];
            end
            dl_re[DELAY-1] <= tail_re;
            dl_im[DELAY-1] <= tail_im;
        end
    end

    // ==================================================================
    // Output register
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_re_o <= '0;
            data_im_o <= '0;
        end else if (phase == PH_BFLY) begin
            data_re_o <= sum_re;
            data_im_o <= sum_im;
        end else if (draining) begin
            // Twiddled difference leaving the head of the line
            data_re_o <= prod_re;
            data_im_o <= prod_im;
        end
    end

endmodule

//--- hdl/fft8_sdf_top.sv
// ===================================================================
// 8-point SDF FFT
// Three DIF stages, output in bit-reversed order
// ===================================================================
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft8_sdf_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_i,
    input  logic signed [`SAMPLE_W-1:0] data_re_i,
    input  logic signed [`SAMPLE_W-1:0] data_im_i,
    output logic                       valid_o,
    output logic signed [`OUT_W-1:0]    data_re_o,
    output logic signed [`OUT_W-1:0]    data_im_o
);
    // Stage 0 to stage 1, one growth bit
    logic                       s0_valid;
    logic signed [`SAMPLE_W:0]   s0_re, s0_im;
    // Stage 1 to stage 2
    logic                       s1_valid;
    logic signed [`SAMPLE_W+1:0] s1_re, s1_im;

    sdf_stage #(.DELAY(`FFT_N / 2), .IN_W(`SAMPLE_W)) u_stage0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .data_re_i (data_re_i),
        .data_im_i (data_im_i),
        .valid_o   (s0_valid),
        .data_re_o (s0_re),
        .data_im_o (s0_im)
    );

    sdf_stage #(.DELAY(`FFT_N / 4), .IN_W(`SAMPLE_W + 1)) u_stage1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (s0_valid),
        .data_re_i (s0_re),
        .data_im_i (s0_im),
        .valid_o   (s1_valid),
        .data_re_o (s1_re),
        .data_im_o (s1_im)
    );

    // Last stage, twiddle is always unity
    sdf_stage #(.DELAY(`FFT_N / 8), .IN_W(`SAMPLE_W + 2)) u_stage2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (s1_valid),
        .data_re_i (s1_re),
        .data_im_i (s1_im),
        .valid_o   (valid_o),
        .data_re_o (data_re_o),
        .data_im_o (data_im_o)
    );

endmodule

//--- verification/fft8_tb.sv
// ======================================================================
// FFT8 SDF testbench
// Random and directed frames against a fixed-point DIF reference model
// ======================================================================
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft8_tb;

    localparam int PERIOD      = 20;
    localparam int LATENCY     = 10;
    localparam int DRAIN_LIMIT = 400;
    // Full-scale input component
    localparam int FULL        = (1 << (`SAMPLE_W - 1)) - 1;

    typedef int frame_t [`FFT_N];

    logic clk = 1'b0;
    logic rst_n;
    logic valid_i;
    logic signed [`SAMPLE_W-1:0] data_re_i, data_im_i;
    logic valid_o;
    logic signed [`OUT_W-1:0] data_re_o, data_im_o;

    logic [31:0] lfsr_q;
    string test_name = "reset";
    // Expected outputs in stream order and frame start times
    int  exp_re_q [$];
    int  exp_im_q [$];
    time start_q [$];
    int  out_pos   = 0;
    int  run_len   = 0;
    int  last_run  = 0;
    int  sat_hits  = 0;

    fft8_sdf_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .data_re_i (data_re_i),
        .data_im_i (data_im_i),
        .valid_o   (valid_o),
        .data_re_o (data_re_o),
        .data_im_o (data_im_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ==================================================================
    // Random source and reference model
    // ==================================================================
    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic int rand_bits(input int nbits);
        int v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    function automatic longint sat_to(input longint v, input int w);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (w - 1)) - 1;
        lo = -(longint'(1) <<< (w - 1));
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    // W8^k in Q1.14
    function automatic void twiddle_of(input int k, output longint re, output longint im);
        case (k)
            0: begin
                re = 16384;
                im = 0;
            end
            1: begin
                re = 11585;
                im = -11585;
            end
            2: begin
                re = 0;
                im = -16384;
            end
            default: begin
                re = -11585;
                im = -11585;
            end
        endcase
    endfunction

    // DIF passes in place leave the result in bit-reversed order
    function automatic void fft_ref(input frame_t xr, input frame_t xi,
                                    output frame_t yr, output frame_t yi);
        longint ar [`FFT_N];
        longint ai [`FFT_N];
        longint dr, di, tr, ti, pr, pim;
        int d, w, base, n, i;
        for (i = 0; i < `FFT_N; i++) begin
            ar[i] = xr[i];
            ai[i] = xi[i];
        end
        d = `FFT_N / 2;
        w = `SAMPLE_W + 1;
        while (d >= 1) begin
            for (base = 0; base < `FFT_N; base += 2 * d) begin
                for (n = 0; n < d; n++) begin
                    dr = ar[base + n] - ar[base + n + d];
                    di = ai[base + n] - ai[base + n + d];
                    ar[base + n] = ar[base + n] + ar[base + n + d];
                    ai[base + n] = ai[base + n] + ai[base + n + d];
                    twiddle_of(n * (`FFT_N / 2) / d, tr, ti);
                    // Shift floors toward minus infinity before the clamp
                    pr  = (dr * tr - di * ti) >>> `COEF_FRAC;
                    pim = (dr * ti + di * tr) >>> `COEF_FRAC;
                    ar[base + n + d] = sat_to(pr, w);
                    ai[base + n + d] = sat_to(pim, w);
                    if (ar[base + n + d] != pr || ai[base + n + d] != pim) begin
                        sat_hits++;
                    end
                end
            end
            d = d / 2;
            w++;
        end
        for (i = 0; i < `FFT_N; i++) begin
            yr[i] = int'(ar[i]);
            yi[i] = int'(ai[i]);
        end
    endfunction

    // ==================================================================
    // Reporting and stimulus
    // ==================================================================
    task automatic value_error(input string what, input string expv, input string actv);
        $display("[ERROR] %s: %s expected %s actual %s", test_name, what, expv, actv);
        $display("TEST FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s (test %s)", msg, test_name);
        $display("TEST FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    // Queue expected values and drive eight consecutive strobes
    task automatic send_frame(input frame_t xr, input frame_t xi,
                              input frame_t er, input frame_t ei);
        for (int i = 0; i < `FFT_N; i++) begin
            exp_re_q.push_back(er[i]);
            exp_im_q.push_back(ei[i]);
        end
        for (int i = 0; i < `FFT_N; i++) begin
            @(posedge clk);
            if (i == 0) begin
                start_q.push_back($time);
            end
            valid_i   <= 1'b1;
            data_re_i <= xr[i][`SAMPLE_W-1:0];
            data_im_i <= xi[i][`SAMPLE_W-1:0];
        end
    endtask

    task automatic send_ref_frame(input frame_t xr, input frame_t xi);
        frame_t er, ei;
        fft_ref(xr, xi, er, ei);
        send_frame(xr, xi, er, ei);
    endtask

    // Signed components in +/- 2^(bits-1)
    task automatic send_random_frame(input int bits);
        frame_t xr, xi;
        for (int i = 0; i < `FFT_N; i++) begin
            xr[i] = rand_bits(bits) - (1 << (bits - 1));
            xi[i] = rand_bits(bits) - (1 << (bits - 1));
        end
        send_ref_frame(xr, xi);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            valid_i <= 1'b0;
        end
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (exp_re_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            assert (cycles < DRAIN_LIMIT)
                else abort_run({"Timed out waiting for the ", what, " outputs to drain"});
        end
        // Any output in the quiet tail is extra
        idle_cycles(LATENCY + 4);
    endtask

    // Square corner levels with a 45 degree step per index
    function automatic int corner_level(input int idx);
        case (idx)
            0, 1, 7: return FULL;
            3, 4, 5: return -FULL;
            default: return 0;
        endcase
    endfunction

    // ==================================================================
    // Comparator sampled mid-cycle
    // ==================================================================
    always @(negedge clk) begin
        int er;
        int ei;
        int act_re;
        int act_im;
        int cycles;
        act_re = data_re_o;
        act_im = data_im_o;
        if (rst_n && valid_o) begin
            run_len++;
            assert (exp_re_q.size() > 0) else abort_run("valid_o was high with no frame pending");
            er = exp_re_q.pop_front();
            ei = exp_im_q.pop_front();
            // First sample of a frame has a fixed latency
            if (out_pos == 0) begin
                cycles = int'(($time - start_q.pop_front() - PERIOD / 2) / PERIOD);
                assert (cycles == LATENCY)
                    else value_error("first output latency", $sformatf("%0d", LATENCY),
                                     $sformatf("%0d", cycles));
            end
            assert (act_re == er && act_im == ei)
                else value_error($sformatf("output position %0d", out_pos),
                                 $sformatf("(%0d, %0d)", er, ei),
                                 $sformatf("(%0d, %0d)", act_re, act_im));
            out_pos = (out_pos + 1) % `FFT_N;
        end else if (run_len != 0) begin
            last_run = run_len;
            run_len  = 0;
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        frame_t xr, xi, er, ei;
        rst_n     = 1'b0;
        valid_i   = 1'b0;
        data_re_i = '0;
        data_im_i = '0;
        lfsr_q    = 32'h9e38_a406;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "idle_after_reset";
        idle_cycles(30);
        @(negedge clk);
        assert (data_re_o == 0 && data_im_o == 0)
            else value_error("output data after reset", "(0, 0)",
                             $sformatf("(%0d, %0d)", data_re_o, data_im_o));

        // Impulse gives a flat spectrum and a constant gives a lone DC bin
        test_name = "impulse_and_dc";
        for (int i = 0; i < `FFT_N; i++) begin
            xr[i] = (i == 0) ? 1000 : 0;
            xi[i] = 0;
            er[i] = 1000;
            ei[i] = 0;
        end
        send_frame(xr, xi, er, ei);
        idle_cycles(3);
        for (int i = 0; i < `FFT_N; i++) begin
            xr[i] = 1000;
            er[i] = (i == 0) ? 8000 : 0;
        end
        send_frame(xr, xi, er, ei);
        idle_cycles(1);
        wait_drain("impulse and DC");

        test_name = "single_random";
        for (int f = 0; f < 6; f++) begin
            send_random_frame(14);
            idle_cycles(1);
            wait_drain("single frame");
        end

        test_name = "back_to_back";
        last_run = 0;
        for (int f = 0; f < 20; f++) begin
            send_random_frame(`SAMPLE_W);
        end
        idle_cycles(1);
        wait_drain("back-to-back");
        assert (last_run == 20 * `FFT_N)
            else value_error("valid_o run length", $sformatf("%0d", 20 * `FFT_N),
                             $sformatf("%0d", last_run));

        test_name = "random_gaps";
        for (int f = 0; f < 12; f++) begin
            send_random_frame(`SAMPLE_W);
            idle_cycles(1 + rand_bits(8) % 12);
        end
        wait_drain("gapped");

        // Rotating full-scale corners in both directions
        test_name = "full_scale_rotation";
        sat_hits = 0;
        for (int r = 0; r < `FFT_N; r++) begin
            for (int dir = -1; dir <= 1; dir += 2) begin
                for (int n = 0; n < `FFT_N; n++) begin
                    xr[n] = corner_level((r + dir * n) & 7);
                    xi[n] = corner_level((r + dir * n - 2) & 7);
                end
                send_ref_frame(xr, xi);
            end
        end
        idle_cycles(1);
        wait_drain("full-scale");
        assert (sat_hits > 0) else abort_run("Full-scale frames never reached saturation");

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- project.f
+incdir+hdl
hdl/fft_pkg.sv
hdl/twiddle_rom.sv
hdl/twiddle_mul.sv
hdl/sdf_stage_ctrl.sv
hdl/sdf_stage.sv
hdl/fft8_sdf_top.sv
verification/fft8_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the FFT8 testbench with Verilator, run it, and judge the log

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing -Wno-fatal --top-module fft8_tb -f project.f > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/Vfft8_tb > "$SIM_LOG" 2>&1 \
    || echo "Build or simulation returned an error, see $BUILD_LOG and $SIM_LOG"

grep -q "TEST PASSED" "$SIM_LOG" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
